// ==== sources.f ====
source/du_pkg.sv
source/du_decode.sv
source/du_regs.sv
source/du_bp_match.sv
source/du_readback.sv
source/debug_unit.sv
verif/tb_debug_unit.sv

// ==== Makefile ====
# Verilator build and run of the debug unit testbench

VERILATOR ?= verilator
TOP       ?= tb_debug_unit
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_debug_unit.sv ====
////////////////////
// Debug unit testbench
// Random stimulus, cycle model of the register bank,
// debug port access and per-test reporting
////////////////////

`timescale 1ns/1ps

module tb_debug_unit;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             dbg_strb_i;
  logic                             dbg_we_i;
  logic [du_pkg::DBG_ADDR_SIZE-1:0] dbg_addr_i;
  logic [31:0]                      dbg_d_i;
  logic                             dbg_ack_o;
  logic [31:0]                      dbg_q_o;
  du_pkg::cpu_obs_t                 cpu_i;
  logic [31:0]                      du_exceptions_i;
  logic [31:0]                      du_ie_o;
  logic                             dbg_bp_o;

  // Shadow state of the model
  logic [1:0]  m_ctrl;
  logic [3:0]  m_hit_bp;
  logic        m_hit_br;
  logic        m_hit_st;
  logic [31:0] m_ie;
  logic [31:0] m_cause;
  logic [2:0]  m_bp_cc [4];
  logic        m_bp_en [4];
  logic [31:0] m_bp_data [4];
  logic        m_dbg_bp;
  logic        pend_we;
  logic [11:0] pend_off;
  logic [31:0] pend_data;

  int          seed;
  int          errors;
  int          checks;
  logic [31:0] watch_adr;
  event        timeout_ev;

  debug_unit UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dbg_strb_i      (dbg_strb_i),
    .dbg_we_i        (dbg_we_i),
    .dbg_addr_i      (dbg_addr_i),
    .dbg_d_i         (dbg_d_i),
    .dbg_ack_o       (dbg_ack_o),
    .dbg_q_o         (dbg_q_o),
    .cpu_i           (cpu_i),
    .du_exceptions_i (du_exceptions_i),
    .du_ie_o         (du_ie_o),
    .dbg_bp_o        (dbg_bp_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial
  begin
    @(timeout_ev);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Index 0..3 are the core registers, 4..11 the breakpoints, above that unused
  function automatic logic [11:0] reg_off(input logic [3:0] i);
    if (i < 4'd4)
      return {8'h00, i};
    return 12'h010 + 12'(i - 4'd4);
  endfunction

  function automatic logic [31:0] bp_ctrl_word(input logic [2:0] cc, input logic en);
    return {25'b0, cc, 2'b00, en, 1'b0};
  endfunction

  function automatic logic [31:0] read_model(input logic [15:0] addr);
    logic [11:0] off;
    logic [1:0]  n;
    off = addr[11:0];
    n   = off[2:1];
    if (addr[15:12] != du_pkg::DBG_INTERNAL)
      return 32'h0;
    if (off == du_pkg::DBG_CTRL)
      return {30'b0, m_ctrl};
    if (off == du_pkg::DBG_HIT)
      return {24'b0, m_hit_bp, 2'b00, m_hit_br, m_hit_st};
    if (off == du_pkg::DBG_IE)
      return m_ie;
    if (off == du_pkg::DBG_CAUSE)
      return m_cause;
    if (off >= 12'h010 && off <= 12'h017)
      return off[0] ? m_bp_data[n] : {25'b0, m_bp_cc[n], 2'b00, m_bp_en[n], 1'b1};
    return 32'h0;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%s: %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED", errors - err0);
  endtask

  task automatic reset_model();
    m_ctrl    = '0;
    m_hit_bp  = '0;
    m_hit_br  = 1'b0;
    m_hit_st  = 1'b0;
    m_ie      = '0;
    m_cause   = '0;
    m_dbg_bp  = 1'b0;
    pend_we   = 1'b0;
    pend_off  = '0;
    pend_data = '0;
    for (int k = 0; k < 4; k++)
    begin
      m_bp_cc[k]   = '0;
      m_bp_en[k]   = 1'b0;
      m_bp_data[k] = '0;
    end
  endtask

  ////////////////////
  // Cycle model
  ////////////////////
  task automatic model_update();
    logic [3:0] bp_p;
    logic       st_p;
    logic       br_p;
    logic       ld;
    logic       stv;
    logic       acc;
    logic       found;
    logic [1:0] n;
    ld  = !cpu_i.mem_exception && !cpu_i.mem_bubble
          && cpu_i.mem_instr[6:2] == du_pkg::OPC_LOAD;
    stv = !cpu_i.mem_exception && !cpu_i.mem_bubble
          && cpu_i.mem_instr[6:2] == du_pkg::OPC_STORE;
    for (int k = 0; k < 4; k++)
    begin
      acc     = cpu_i.dmem_ack && cpu_i.mem_adr == m_bp_data[k];
      bp_p[k] = 1'b0;
      if (m_bp_en[k])
      begin
        case (m_bp_cc[k])
          du_pkg::BP_CC_FETCH:    bp_p[k] = cpu_i.pd_pc == m_bp_data[k];
          du_pkg::BP_CC_LD_ADR:   bp_p[k] = acc && ld;
          du_pkg::BP_CC_ST_ADR:   bp_p[k] = acc && stv;
          du_pkg::BP_CC_LDST_ADR: bp_p[k] = acc && (ld || stv);
          default:                bp_p[k] = 1'b0;
        endcase
      end
    end
    st_p = m_ctrl[0] && !cpu_i.if_nxt_bubble;
    br_p = m_ctrl[1] && !cpu_i.if_bubble && cpu_i.if_instr[6:2] == du_pkg::OPC_BRANCH;
    // Break output sees the flags from before this edge
    m_dbg_bp = (|m_hit_bp) || m_hit_br || m_hit_st || (|du_exceptions_i);

    if (pend_we && pend_off == du_pkg::DBG_HIT)
      {m_hit_bp, m_hit_br, m_hit_st} = {pend_data[7:4], pend_data[1], pend_data[0]};
    else
    begin
      m_hit_bp = m_hit_bp | bp_p;
      m_hit_br = m_hit_br | br_p;
      m_hit_st = m_hit_st | st_p;
    end

    found = 1'b0;
    if (pend_we && pend_off == du_pkg::DBG_CAUSE)
      m_cause = pend_data;
    else if (|du_exceptions_i[15:0])
    begin
      for (int k = 0; k < 16; k++)
      begin
        if (!found && du_exceptions_i[k])
        begin
          m_cause = 32'(k);
          found   = 1'b1;
        end
      end
    end
    else if (|du_exceptions_i[31:16])
    begin
      for (int k = 0; k < 16; k++)
      begin
        if (!found && du_exceptions_i[16+k])
        begin
          m_cause = 32'h8000_0000 | 32'(k);
          found   = 1'b1;
        end
      end
    end

    if (pend_we)
    begin
      n = pend_off[2:1];
      if (pend_off == du_pkg::DBG_CTRL)
        m_ctrl = pend_data[1:0];
      if (pend_off == du_pkg::DBG_IE)
        m_ie = pend_data;
      if (pend_off[11:3] == 9'h002 && pend_off[0])
        m_bp_data[n] = pend_data;
      if (pend_off[11:3] == 9'h002 && !pend_off[0])
      begin
        m_bp_en[n] = pend_data[1];
        m_bp_cc[n] = pend_data[6:4];
      end
    end
    pend_we = 1'b0;
  endtask

  // One clock, then drive point 1 ns after the edge
  task automatic tick();
    @(posedge clk_i);
    model_update();
    #1;
    check("dbg_bp_o", 32'(dbg_bp_o), 32'(m_dbg_bp));
    check("du_ie_o", du_ie_o, m_ie);
  endtask

  ////////////////////
  // Debug port access
  ////////////////////
  task automatic access(input logic we, input logic [15:0] addr, input logic [31:0] data,
                        output logic [31:0] q);
    int          cnt;
    logic        got_ack;
    logic [31:0] exp_q;
    dbg_strb_i = 1'b1;
    dbg_we_i   = we;
    dbg_addr_i = addr;
    dbg_d_i    = data;
    cnt        = 0;
    got_ack    = 1'b0;
    exp_q      = 32'hx;
    q          = 32'h0;
    while (!got_ack && cnt < 20)
    begin
      tick();
      cnt++;
      // Write lands at edge 2
      if (cnt == 1 && we && addr[15:12] == du_pkg::DBG_INTERNAL)
      begin
        pend_we   = 1'b1;
        pend_off  = addr[11:0];
        pend_data = data;
      end
      if (cnt == 2)
        exp_q = read_model(addr);
      got_ack = dbg_ack_o;
    end
    if (!got_ack)
    begin
      errors++;
      $display("Timeout: no acknowledge for address %h within 20 cycles", addr);
      -> timeout_ev;
    end
    else
    begin
      check("ack edge", cnt, 32'd3);
      check($sformatf("dbg_q_o@%h", addr), dbg_q_o, exp_q);
      q          = dbg_q_o;
      dbg_strb_i = 1'b0;
      dbg_we_i   = 1'b0;
      tick();
      check("dbg_ack_o", 32'(dbg_ack_o), 32'h0);
    end
  endtask

  task automatic write_reg(input logic [11:0] off, input logic [31:0] data);
    logic [31:0] q;
    access(1'b1, {du_pkg::DBG_INTERNAL, off}, data, q);
  endtask

  task automatic read_reg(input logic [11:0] off, output logic [31:0] q);
    access(1'b0, {du_pkg::DBG_INTERNAL, off}, 32'h0, q);
  endtask

  ////////////////////
  // Core stimulus
  ////////////////////
  task automatic park_cpu();
    cpu_i.pd_pc         = ~watch_adr;
    cpu_i.if_nxt_bubble = 1'b1;
    cpu_i.if_bubble     = 1'b1;
    cpu_i.if_instr      = '0;
    cpu_i.mem_bubble    = 1'b1;
    cpu_i.mem_instr     = '0;
    cpu_i.mem_exception = 1'b0;
    cpu_i.mem_adr       = '0;
    cpu_i.dmem_ack      = 1'b0;
  endtask

  task automatic drive_mem();
    logic [31:0] r;
    logic [4:0]  opc;
    r = rnd();
    case (r[1:0])
      2'd0:    opc = du_pkg::OPC_LOAD;
      2'd1:    opc = du_pkg::OPC_STORE;
      2'd2:    opc = du_pkg::OPC_BRANCH;
      default: opc = r[6:2];
    endcase
    cpu_i.mem_instr     = {r[31:7], opc, 2'b11};
    cpu_i.mem_bubble    = r[8] & r[9];
    cpu_i.mem_exception = r[10] & r[11];
    cpu_i.dmem_ack      = r[12] | r[13];
    cpu_i.mem_adr       = r[14] ? watch_adr : rnd();
    // A disabled fetch breakpoint must ignore a matching PC
    cpu_i.pd_pc         = r[15] ? watch_adr : ~watch_adr;
  endtask

  task automatic drive_fetch();
    logic [31:0] r;
    logic [31:0] t;
    logic [4:0]  opc;
    r = rnd();
    t = rnd();
    opc = (r[3:2] != 2'b00) ? du_pkg::OPC_BRANCH : r[8:4];
    cpu_i.if_nxt_bubble = r[0];
    cpu_i.if_bubble     = r[1];
    cpu_i.if_instr      = {t[31:7], opc, 2'b11};
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial
  begin
    int          err0;
    int          n;
    logic [31:0] r;
    logic [31:0] q;
    logic [11:0] off;
    logic [3:0]  bank;
    seed            = 32'h96;
    errors          = 0;
    checks          = 0;
    watch_adr       = '0;
    rst_ni          = 1'b0;
    dbg_strb_i      = 1'b0;
    dbg_we_i        = 1'b0;
    dbg_addr_i      = '0;
    dbg_d_i         = '0;
    du_exceptions_i = '0;
    park_cpu();
    reset_model();
    for (int i = 0; i < 16; i++)
      @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // Test 1: reset values, random register traffic, foreign banks
    err0 = errors;
    for (int i = 0; i < 16; i++)
      read_reg(reg_off(4'(i)), q);
    for (int i = 0; i < 80; i++)
    begin
      r    = rnd();
      off  = (r[3] && r[12]) ? r[31:20] : reg_off(r[7:4]);
      bank = (r[2:1] == 2'b00) ? (r[11:8] | 4'h1) : du_pkg::DBG_INTERNAL;
      access(r[13], {bank, off}, rnd(), q);
    end
    for (int i = 0; i < 8; i++)
    begin
      r = rnd();
      access(1'b0, {r[11:8] | 4'h1, reg_off(r[7:4])}, 32'h0, q);
      check("other bank read", q, 32'h0);
    end
    report_test("Test 1 register access", err0);

    // Test 2: acknowledge timing on back-to-back accesses
    err0 = errors;
    for (int i = 0; i < 24; i++)
    begin
      r = rnd();
      access(r[0], {du_pkg::DBG_INTERNAL, reg_off(r[7:4])}, rnd(), q);
    end
    report_test("Test 2 acknowledge timing", err0);

    // Test 3: fetch breakpoint
    err0 = errors;
    for (int k = 0; k < 4; k++)
      write_reg(du_pkg::DBG_BPCTRL0 + 12'(2 * k), 32'h0);
    write_reg(du_pkg::DBG_CTRL, 32'h0);
    write_reg(du_pkg::DBG_HIT, 32'h0);
    r         = rnd();
    n         = 32'(r[1:0]);
    watch_adr = rnd();
    park_cpu();
    write_reg(du_pkg::DBG_BPDATA0 + 12'(2 * n), watch_adr);
    write_reg(du_pkg::DBG_BPCTRL0 + 12'(2 * n), bp_ctrl_word(du_pkg::BP_CC_FETCH, 1'b1));
    for (int j = 0; j < 5; j++)
    begin
      for (int i = 0; i < 8; i++)
      begin
        r           = rnd();
        cpu_i.pd_pc = (r[1:0] == 2'b00) ? watch_adr : rnd();
        tick();
      end
      park_cpu();
      read_reg(du_pkg::DBG_HIT, q);
    end
    write_reg(du_pkg::DBG_HIT, 32'h0);
    read_reg(du_pkg::DBG_HIT, q);
    check("HIT after clear", q, 32'h0);
    report_test("Test 3 fetch breakpoint", err0);

    // Test 4: load, store and load/store address breakpoints
    err0      = errors;
    watch_adr = rnd();
    park_cpu();
    for (int k = 0; k < 4; k++)
      write_reg(du_pkg::DBG_BPDATA0 + 12'(2 * k), watch_adr);
    write_reg(12'h010, bp_ctrl_word(du_pkg::BP_CC_LD_ADR, 1'b1));
    write_reg(12'h012, bp_ctrl_word(du_pkg::BP_CC_ST_ADR, 1'b1));
    write_reg(12'h014, bp_ctrl_word(du_pkg::BP_CC_LDST_ADR, 1'b1));
    write_reg(12'h016, bp_ctrl_word(du_pkg::BP_CC_FETCH, 1'b0));
    for (int j = 0; j < 10; j++)
    begin
      write_reg(du_pkg::DBG_HIT, 32'h0);
      for (int i = 0; i < 6; i++)
      begin
        drive_mem();
        tick();
      end
      park_cpu();
      read_reg(du_pkg::DBG_HIT, q);
    end
    report_test("Test 4 address breakpoints", err0);

    // Test 5: cause encoding and exception enables
    err0 = errors;
    write_reg(du_pkg::DBG_CAUSE, rnd());
    read_reg(du_pkg::DBG_CAUSE, q);
    for (int j = 0; j < 8; j++)
    begin
      write_reg(du_pkg::DBG_IE, rnd());
      for (int i = 0; i < 4; i++)
      begin
        r = rnd();
        case (r[1:0])
          2'd0:    du_exceptions_i = 32'h0;
          2'd1:    du_exceptions_i = rnd() & 32'h0000_FFFF;
          2'd2:    du_exceptions_i = rnd() & 32'hFFFF_0000;
          default: du_exceptions_i = rnd();
        endcase
        tick();
      end
      du_exceptions_i = 32'h0;
      read_reg(du_pkg::DBG_CAUSE, q);
    end
    report_test("Test 5 cause and enables", err0);

    // Test 6: single step and branch break
    err0 = errors;
    for (int k = 0; k < 4; k++)
      write_reg(du_pkg::DBG_BPCTRL0 + 12'(2 * k), 32'h0);
    for (int j = 0; j < 10; j++)
    begin
      r = rnd();
      write_reg(du_pkg::DBG_CTRL, {30'b0, r[1:0]});
      write_reg(du_pkg::DBG_HIT, 32'h0);
      for (int i = 0; i < 6; i++)
      begin
        drive_fetch();
        tick();
      end
      park_cpu();
      read_reg(du_pkg::DBG_HIT, q);
    end
    write_reg(du_pkg::DBG_CTRL, 32'h0);
    report_test("Test 6 step and branch break", err0);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== source/debug_unit.sv ====
////////////////////
// Debug unit top level
// Port decode, register bank, hit logic, readback
////////////////////

`timescale 1ns/1ps

module debug_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Debug port
  input  logic                             dbg_strb_i,
  input  logic                             dbg_we_i,
  input  logic [du_pkg::DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  logic [du_pkg::XLEN-1:0]          dbg_d_i,
  output logic                             dbg_ack_o,
  output logic [du_pkg::XLEN-1:0]          dbg_q_o,

  // Core side
  input  du_pkg::cpu_obs_t                 cpu_i,
  input  logic [31:0]                      du_exceptions_i,
  output logic [31:0]                      du_ie_o,
  output logic                             dbg_bp_o
);

  du_pkg::du_wcmd_t                      wcmd;
  logic                                  rd_internal;
  logic [du_pkg::DU_ADDR_SIZE-1:0]       rd_offset;
  logic [1:0]                            ctrl;
  du_pkg::hit_t                          hit;
  du_pkg::hit_t                          hit_set;
  logic [du_pkg::XLEN-1:0]               cause;
  du_pkg::bp_t [du_pkg::BREAKPOINTS-1:0] bp;

  du_decode u_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dbg_strb_i    (dbg_strb_i),
    .dbg_we_i      (dbg_we_i),
    .dbg_addr_i    (dbg_addr_i),
    .dbg_d_i       (dbg_d_i),
    .dbg_ack_o     (dbg_ack_o),
    .wcmd_o        (wcmd),
    .rd_internal_o (rd_internal),
    .rd_offset_o   (rd_offset)
  );

  du_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wcmd_i       (wcmd),
    .hit_set_i    (hit_set),
    .exceptions_i (du_exceptions_i),
    .ctrl_o       (ctrl),
    .hit_o        (hit),
    .ie_o         (du_ie_o),
    .cause_o      (cause),
    .bp_o         (bp),
    .dbg_bp_o     (dbg_bp_o)
  );

  du_bp_match u_bp_match (
    .cpu_i  (cpu_i),
    .ctrl_i (ctrl),
    .bp_i   (bp),
    .hit_o  (hit_set)
  );

  du_readback u_readback (
    .clk_i         (clk_i),
    .rd_internal_i (rd_internal),
    .rd_offset_i   (rd_offset),
    .ctrl_i        (ctrl),
    .hit_i         (hit),
    .ie_i          (du_ie_o),
    .cause_i       (cause),
    .bp_i          (bp),
    .dbg_q_o       (dbg_q_o)
  );

endmodule

// ==== source/du_readback.sv ====
////////////////////
// Debug port read data
// Register packing and output register
////////////////////

`timescale 1ns/1ps

module du_readback (
  input  logic                                  clk_i,
  input  logic                                  rd_internal_i,
  input  logic [du_pkg::DU_ADDR_SIZE-1:0]       rd_offset_i,
  input  logic [1:0]                            ctrl_i,
  input  du_pkg::hit_t                          hit_i,
  input  logic [31:0]                           ie_i,
  input  logic [du_pkg::XLEN-1:0]               cause_i,
  input  du_pkg::bp_t [du_pkg::BREAKPOINTS-1:0] bp_i,
  output logic [du_pkg::XLEN-1:0]               dbg_q_o
);

  logic [du_pkg::XLEN-1:0] rd_word;
  logic                    bp_sel;
  logic [1:0]              bp_idx;

  assign bp_sel = rd_offset_i[du_pkg::DU_ADDR_SIZE-1:3]
                  == du_pkg::DBG_BPCTRL0[du_pkg::DU_ADDR_SIZE-1:3];
  assign bp_idx = rd_offset_i[2:1];

  // Same field layout as the write side
  always_comb
  begin
    rd_word = '0;
    case (rd_offset_i)
      du_pkg::DBG_CTRL:  rd_word[1:0] = ctrl_i;
      du_pkg::DBG_HIT:   rd_word[7:0] = {hit_i.bp, 2'b00, hit_i.branch_break, hit_i.instr_break};
      du_pkg::DBG_IE:    rd_word[31:0] = ie_i;
      du_pkg::DBG_CAUSE: rd_word = cause_i;
      default:           rd_word = '0;
    endcase
    if (bp_sel && !rd_offset_i[0])
      rd_word[6:0] = {bp_i[bp_idx].ctrl.cc, 2'b00, bp_i[bp_idx].ctrl.enabled,
                      bp_i[bp_idx].ctrl.implemented};
    if (bp_sel && rd_offset_i[0])
      rd_word = bp_i[bp_idx].data;
  end

  // Other banks read zero
  always_ff @(posedge clk_i)
  begin
    dbg_q_o <= rd_internal_i ? rd_word : '0;
  end

endmodule

// ==== source/du_bp_match.sv ====
////////////////////
// Breakpoint hit detection
// Address and fetch compares, single step, branch break
////////////////////

`timescale 1ns/1ps

module du_bp_match (
  input  du_pkg::cpu_obs_t                      cpu_i,
  input  logic [1:0]                            ctrl_i,
  input  du_pkg::bp_t [du_pkg::BREAKPOINTS-1:0] bp_i,
  output du_pkg::hit_t                          hit_o
);

  logic                           mem_read;
  logic                           mem_write;
  logic                           adr_hit;
  logic [du_pkg::BREAKPOINTS-1:0] bp_hit;

  // Memory access kind from the memory stage
  assign mem_read  = ~cpu_i.mem_exception & ~cpu_i.mem_bubble
                     & (cpu_i.mem_instr[6:2] == du_pkg::OPC_LOAD);
  assign mem_write = ~cpu_i.mem_exception & ~cpu_i.mem_bubble
                     & (cpu_i.mem_instr[6:2] == du_pkg::OPC_STORE);

  always_comb
  begin
    adr_hit = 1'b0;
    for (int n = 0; n < du_pkg::BREAKPOINTS; n++)
    begin
      // Acknowledged access to the watched address
      adr_hit = cpu_i.dmem_ack & (cpu_i.mem_adr == bp_i[n].data);
      if (!bp_i[n].ctrl.enabled || !bp_i[n].ctrl.implemented)
        bp_hit[n] = 1'b0;
      else
      begin
        case (bp_i[n].ctrl.cc)
          du_pkg::BP_CC_FETCH:    bp_hit[n] = cpu_i.pd_pc == bp_i[n].data;
          du_pkg::BP_CC_LD_ADR:   bp_hit[n] = adr_hit & mem_read;
          du_pkg::BP_CC_ST_ADR:   bp_hit[n] = adr_hit & mem_write;
          du_pkg::BP_CC_LDST_ADR: bp_hit[n] = adr_hit & (mem_read | mem_write);
          default:                bp_hit[n] = 1'b0;
        endcase
      end
    end
  end

  // Bit 0 is single step, bit 1 is branch break
  assign hit_o.instr_break  = ctrl_i[0] & ~cpu_i.if_nxt_bubble;
  assign hit_o.branch_break = ctrl_i[1] & ~cpu_i.if_bubble
                              & (cpu_i.if_instr[6:2] == du_pkg::OPC_BRANCH);
  assign hit_o.bp           = bp_hit;

endmodule

// ==== source/du_regs.sv ====
////////////////////
// Internal debug register bank
// Control, sticky hit flags, IE mask, cause
// encoding and the breakpoint registers
////////////////////

`timescale 1ns/1ps

module du_regs (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  du_pkg::du_wcmd_t                         wcmd_i,
  input  du_pkg::hit_t                             hit_set_i,
  input  logic [31:0]                              exceptions_i,
  output logic [1:0]                               ctrl_o,
  output du_pkg::hit_t                             hit_o,
  output logic [31:0]                              ie_o,
  output logic [du_pkg::XLEN-1:0]                  cause_o,
  output du_pkg::bp_t [du_pkg::BREAKPOINTS-1:0]    bp_o,
  output logic                                     dbg_bp_o
);

  logic [1:0]              ctrl_q;
  du_pkg::hit_t            hit_q;
  logic [31:0]             ie_q;
  logic [du_pkg::XLEN-1:0] cause_q;
  logic [du_pkg::XLEN-1:0] trap_cause;
  logic [du_pkg::XLEN-1:0] irq_cause;
  logic [2:0]              bp_cc_q   [du_pkg::BREAKPOINTS];
  logic                    bp_en_q   [du_pkg::BREAKPOINTS];
  logic [du_pkg::XLEN-1:0] bp_data_q [du_pkg::BREAKPOINTS];
  logic                    wr_ctrl, wr_hit, wr_ie, wr_cause, wr_bp;
  logic [1:0]              bp_idx;

  // Index of the lowest set bit
  function automatic logic [3:0] first_set(input logic [15:0] vec);
    logic [3:0] idx;
    idx = '0;
    for (int i = 15; i >= 0; i--)
    begin
      if (vec[i])
        idx = 4'(i);
    end
    return idx;
  endfunction

  ////////////////////
  // Write decode
  ////////////////////
  assign wr_ctrl  = wcmd_i.we && (wcmd_i.offset == du_pkg::DBG_CTRL);
  assign wr_hit   = wcmd_i.we && (wcmd_i.offset == du_pkg::DBG_HIT);
  assign wr_ie    = wcmd_i.we && (wcmd_i.offset == du_pkg::DBG_IE);
  assign wr_cause = wcmd_i.we && (wcmd_i.offset == du_pkg::DBG_CAUSE);
  // Breakpoint window covers 0x010 to 0x017
  assign wr_bp    = wcmd_i.we && (wcmd_i.offset[du_pkg::DU_ADDR_SIZE-1:3]
                                  == du_pkg::DBG_BPCTRL0[du_pkg::DU_ADDR_SIZE-1:3]);
  assign bp_idx   = wcmd_i.offset[2:1];

  always_comb
  begin
    trap_cause            = '0;
    trap_cause[3:0]       = first_set(exceptions_i[15:0]);
    irq_cause             = '0;
    irq_cause[3:0]        = first_set(exceptions_i[31:16]);
    irq_cause[du_pkg::XLEN-1] = 1'b1;
  end

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ctrl_q   <= '0;
      hit_q    <= '0;
      ie_q     <= '0;
      cause_q  <= '0;
      dbg_bp_o <= 1'b0;
      for (int n = 0; n < du_pkg::BREAKPOINTS; n++)
      begin
        bp_cc_q[n]   <= '0;
        bp_en_q[n]   <= 1'b0;
        bp_data_q[n] <= '0;
      end
    end
    else
    begin
      if (wr_ctrl)
        ctrl_q <= wcmd_i.data[1:0];

      // Host write wins over new hits
      if (wr_hit)
      begin
        hit_q.instr_break  <= wcmd_i.data[0];
        hit_q.branch_break <= wcmd_i.data[1];
        hit_q.bp           <= wcmd_i.data[7:4];
      end
      else
        hit_q <= hit_q | hit_set_i;

      if (wr_ie)
        ie_q <= wcmd_i.data[31:0];

      if (wr_cause)
        cause_q <= wcmd_i.data;
      else if (|exceptions_i[15:0])
        cause_q <= trap_cause;
      else if (|exceptions_i[31:16])
        cause_q <= irq_cause;

      if (wr_bp && !wcmd_i.offset[0])
      begin
        bp_en_q[bp_idx] <= wcmd_i.data[1];
        bp_cc_q[bp_idx] <= wcmd_i.data[6:4];
      end
      if (wr_bp && wcmd_i.offset[0])
        bp_data_q[bp_idx] <= wcmd_i.data;

      dbg_bp_o <= (|hit_q) | (|exceptions_i);
    end
  end

  always_comb
  begin
    for (int n = 0; n < du_pkg::BREAKPOINTS; n++)
    begin
      bp_o[n].ctrl.cc          = bp_cc_q[n];
      bp_o[n].ctrl.enabled     = bp_en_q[n];
      bp_o[n].ctrl.implemented = 1'b1;
      bp_o[n].data             = bp_data_q[n];
    end
  end

  assign ctrl_o  = ctrl_q;
  assign hit_o   = hit_q;
  assign ie_o    = ie_q;
  assign cause_o = cause_q;

  cause_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!wr_cause && exceptions_i == '0) |=> $stable(cause_q));

endmodule

// ==== source/du_decode.sv ====
////////////////////
// Debug port decode
// Acknowledge sequencing and write command register
////////////////////

`timescale 1ns/1ps

module du_decode (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             dbg_strb_i,
  input  logic                             dbg_we_i,
  input  logic [du_pkg::DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  logic [du_pkg::XLEN-1:0]          dbg_d_i,
  output logic                             dbg_ack_o,
  output du_pkg::du_wcmd_t                 wcmd_o,
  output logic                             rd_internal_o,
  output logic [du_pkg::DU_ADDR_SIZE-1:0]  rd_offset_o
);

  logic                            strb_dly_q;
  logic [2:0]                      ack_q;
  logic                            sel_internal;
  logic                            first_cycle;
  logic                            we_q;
  logic [du_pkg::DU_ADDR_SIZE-1:0] offset_q;
  logic [du_pkg::XLEN-1:0]         data_q;

  assign sel_internal = dbg_addr_i[du_pkg::DBG_ADDR_SIZE-1:du_pkg::DU_ADDR_SIZE]
                        == du_pkg::DBG_INTERNAL;
  // Only the first strobe cycle may write
  assign first_cycle  = dbg_strb_i & ~strb_dly_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      strb_dly_q <= 1'b0;
      we_q       <= 1'b0;
      ack_q      <= '0;
    end
    else
    begin
      strb_dly_q <= dbg_strb_i;
      we_q       <= first_cycle & dbg_we_i & sel_internal;
      // Fills from the top, ack leaves bit 0 and clears the shifter
      ack_q      <= {3{dbg_strb_i & ~ack_q[0]}} & {1'b1, ack_q[2:1]};
    end
  end

  // Address and data are held by the host for the whole access
  always_ff @(posedge clk_i)
  begin
    offset_q      <= dbg_addr_i[du_pkg::DU_ADDR_SIZE-1:0];
    data_q        <= dbg_d_i;
    rd_internal_o <= sel_internal;
  end

  assign dbg_ack_o   = ack_q[0];
  assign rd_offset_o = offset_q;
  assign wcmd_o      = '{we: we_q, offset: offset_q, data: data_q};

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_ack_o |=> !dbg_ack_o);

endmodule

// ==== source/du_pkg.sv ====
////////////////////
// Debug unit shared definitions
// Widths, register offsets, condition codes,
// opcode fields and the structs passed between blocks
////////////////////

package du_pkg;

  ////////////////////
  // Widths and counts
  ////////////////////
  localparam int XLEN          = 32;
  localparam int DBG_ADDR_SIZE = 16;
  localparam int DU_ADDR_SIZE  = 12;
  localparam int BREAKPOINTS   = 4;

  // Bank code in the upper address bits
  localparam logic [DBG_ADDR_SIZE-DU_ADDR_SIZE-1:0] DBG_INTERNAL = 4'h0;

  ////////////////////
  // Internal register offsets
  ////////////////////
  localparam logic [DU_ADDR_SIZE-1:0] DBG_CTRL    = 12'h000;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_HIT     = 12'h001;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_IE      = 12'h002;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_CAUSE   = 12'h003;
  // Breakpoint n sits at BPCTRL0 + 2n and BPDATA0 + 2n
  localparam logic [DU_ADDR_SIZE-1:0] DBG_BPCTRL0 = 12'h010;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_BPDATA0 = 12'h011;

  // Breakpoint condition codes
  localparam logic [2:0] BP_CC_FETCH    = 3'd0;
  localparam logic [2:0] BP_CC_LD_ADR   = 3'd1;
  localparam logic [2:0] BP_CC_ST_ADR   = 3'd2;
  localparam logic [2:0] BP_CC_LDST_ADR = 3'd3;

  // Major opcodes, instruction bits 6:2
  localparam logic [4:0] OPC_LOAD   = 5'h00;
  localparam logic [4:0] OPC_STORE  = 5'h08;
  localparam logic [4:0] OPC_BRANCH = 5'h18;

  ////////////////////
  // Structs
  ////////////////////
  typedef struct packed {
    logic                    we;
    logic [DU_ADDR_SIZE-1:0] offset;
    logic [XLEN-1:0]         data;
  } du_wcmd_t;

  typedef struct packed {
    logic [2:0] cc;
    logic       enabled;
    logic       implemented;
  } bp_ctrl_t;

  typedef struct packed {
    bp_ctrl_t        ctrl;
    logic [XLEN-1:0] data;
  } bp_t;

  typedef struct packed {
    logic [BREAKPOINTS-1:0] bp;
    logic                   branch_break;
    logic                   instr_break;
  } hit_t;

  // Core state seen by the debug unit
  typedef struct packed {
    logic [XLEN-1:0] pd_pc;
    logic            if_nxt_bubble;
    logic            if_bubble;
    logic [31:0]     if_instr;
    logic            mem_bubble;
    logic [31:0]     mem_instr;
    logic            mem_exception;
    logic [XLEN-1:0] mem_adr;
    logic            dmem_ack;
  } cpu_obs_t;

endpackage
